// File: logic/cache_pkg.sv
// data cache package: shared widths, data types and opcodes
package cache_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    // byte address
    localparam int unsigned addr_w = 32;
    // one data word and its byte enables
    localparam int unsigned word_w = 64;
    localparam int unsigned be_w = word_w / 8;
    // a line is two words
    localparam int unsigned words_per_line = 2;
    localparam int unsigned line_w = word_w * words_per_line;
    // word select inside a line, and the whole line byte offset
    localparam int unsigned word_off_w = $clog2(words_per_line);
    localparam int unsigned byte_off_w = $clog2(line_w / 8);

    // ------------------------------
    // data types
    // ------------------------------
    typedef logic [word_w-1:0] word_t;
    typedef logic [line_w-1:0] line_t;
    typedef logic [be_w-1:0] be_t;
    typedef logic [line_w/8-1:0] line_be_t;

    // request class, encoded as {bypass, we}
    typedef enum logic [1:0] {
        op_load,
        op_store,
        op_bypass_load,
        op_bypass_store
    } op_e;

endpackage

// File: logic/req_decode.sv
// decode stage: classifies a core request, splits its address and holds it
`timescale 1ns/10ps

module req_decode #(
    parameter int unsigned num_sets = 16,
    localparam int unsigned idx_w = $clog2(num_sets),
    localparam int unsigned tag_w = cache_pkg::addr_w - idx_w - cache_pkg::byte_off_w
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 req_i,
    input  logic                                 we_i,
    input  logic                                 bypass_i,
    input  logic [cache_pkg::addr_w-1:0]         addr_i,
    input  cache_pkg::be_t                       be_i,
    input  cache_pkg::word_t                     wdata_i,
    input  logic                                 accept_i,
    output logic [idx_w-1:0]                     rd_index_o,
    output cache_pkg::op_e                       op_o,
    output logic [tag_w-1:0]                     tag_o,
    output logic [idx_w-1:0]                     index_o,
    output logic [cache_pkg::word_off_w-1:0]     word_sel_o,
    output cache_pkg::be_t                       be_o,
    output cache_pkg::word_t                     wdata_o
);
    import cache_pkg::*;

    // array read goes out in the accept cycle, straight from the core address
    assign rd_index_o = addr_i[byte_off_w +: idx_w];

    // class of the incoming request
    // the execute stage keeps its own copy once accepted
    always_comb begin
        case ({bypass_i, we_i})
            2'b00:   op_o = op_load;
            2'b01:   op_o = op_store;
            2'b10:   op_o = op_bypass_load;
            default: op_o = op_bypass_store;
        endcase
    end

    // address fields stay fixed while the request executes
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tag_o      <= '0;
            index_o    <= '0;
            word_sel_o <= '0;
        end else if (req_i && accept_i) begin
            tag_o      <= addr_i[addr_w-1 -: tag_w];
            index_o    <= addr_i[byte_off_w +: idx_w];
            word_sel_o <= addr_i[byte_off_w-1 -: word_off_w];
        end
    end

    // store payload
    always_ff @(posedge clk_i) begin
        if (req_i && accept_i) begin
            be_o    <= be_i;
            wdata_o <= wdata_i;
        end
    end

endmodule

// File: logic/cache_array.sv
// cache array: tag, valid and data storage per way and set with round-robin victim
`timescale 1ns/10ps

module cache_array #(
    parameter int unsigned num_ways = 2,
    parameter int unsigned num_sets = 16,
    localparam int unsigned idx_w = $clog2(num_sets),
    localparam int unsigned tag_w = cache_pkg::addr_w - idx_w - cache_pkg::byte_off_w,
    localparam int unsigned ptr_w = (num_ways > 1) ? $clog2(num_ways) : 1
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 rd_en_i,
    input  logic [idx_w-1:0]                     rd_index_i,
    input  logic                                 wr_en_i,
    input  logic [num_ways-1:0]                  wr_way_i,
    input  logic [idx_w-1:0]                     wr_index_i,
    input  logic [tag_w-1:0]                     wr_tag_i,
    input  cache_pkg::line_t                     wr_line_i,
    input  cache_pkg::line_be_t                  wr_be_i,
    input  logic                                 fill_i,
    input  logic [idx_w-1:0]                     victim_index_i,
    output logic [num_ways-1:0][tag_w-1:0]       tags_o,
    output logic [num_ways-1:0]                  valids_o,
    output cache_pkg::line_t [num_ways-1:0]      lines_o,
    output logic [num_ways-1:0]                  victim_way_o
);
    import cache_pkg::*;

    localparam int unsigned line_bytes = $bits(line_be_t);

    logic [tag_w-1:0] tag_mem [num_ways][num_sets];
    line_t data_mem [num_ways][num_sets];
    logic [num_ways-1:0][num_sets-1:0] valid_q;
    // next victim per set
    logic [num_sets-1:0][ptr_w-1:0] rr_q;

    // ------------------------------
    // storage
    // ------------------------------
    always_ff @(posedge clk_i) begin
        for (int unsigned w = 0; w < num_ways; w++) begin
            if (wr_en_i && wr_way_i[w]) begin
                // tag only changes on a line fill
                if (fill_i) begin
                    tag_mem[w][wr_index_i] <= wr_tag_i;
                end
                for (int unsigned b = 0; b < line_bytes; b++) begin
                    if (wr_be_i[b]) begin
                        data_mem[w][wr_index_i][b*8 +: 8] <= wr_line_i[b*8 +: 8];
                    end
                end
            end
        end
    end

    // synchronous read, all ways at once
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            for (int unsigned w = 0; w < num_ways; w++) begin
                tags_o[w]  <= tag_mem[w][rd_index_i];
                lines_o[w] <= data_mem[w][rd_index_i];
            end
        end
    end

    // ------------------------------
    // valid bits and victim pointer
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            valids_o <= '0;
            rr_q     <= '0;
        end else begin
            if (rd_en_i) begin
                for (int unsigned w = 0; w < num_ways; w++) begin
                    valids_o[w] <= valid_q[w][rd_index_i];
                end
            end
            if (wr_en_i && fill_i) begin
                for (int unsigned w = 0; w < num_ways; w++) begin
                    if (wr_way_i[w]) begin
                        valid_q[w][wr_index_i] <= 1'b1;
                    end
                end
                // advance past the way just filled
                if (rr_q[wr_index_i] == ptr_w'(num_ways - 1)) begin
                    rr_q[wr_index_i] <= '0;
                end else begin
                    rr_q[wr_index_i] <= rr_q[wr_index_i] + 1'b1;
                end
            end
        end
    end

    // one-hot victim for the held set
    always_comb begin
        victim_way_o = '0;
        victim_way_o[rr_q[victim_index_i]] = 1'b1;
    end

endmodule

// File: logic/ctrl_fsm.sv
// execute stage: controller FSM for lookup, store merge, refill and memory writes
`timescale 1ns/10ps

module ctrl_fsm #(
    parameter int unsigned num_ways = 2,
    parameter int unsigned num_sets = 16,
    localparam int unsigned idx_w = $clog2(num_sets),
    localparam int unsigned tag_w = cache_pkg::addr_w - idx_w - cache_pkg::byte_off_w
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic                                 req_i,
    input  cache_pkg::op_e                       op_i,
    input  logic [tag_w-1:0]                     tag_i,
    input  logic [idx_w-1:0]                     index_i,
    input  logic [cache_pkg::word_off_w-1:0]     word_sel_i,
    input  cache_pkg::be_t                       be_i,
    input  cache_pkg::word_t                     wdata_i,
    input  logic                                 hit_i,
    input  logic [num_ways-1:0]                  hit_way_i,
    input  logic [num_ways-1:0]                  victim_way_i,
    input  logic                                 mem_gnt_i,
    input  logic                                 mem_rvalid_i,
    input  cache_pkg::line_t                     mem_rdata_i,
    output logic                                 accept_o,
    output logic                                 gnt_o,
    output logic                                 rvalid_o,
    output logic                                 busy_o,
    output logic                                 rd_en_o,
    output logic                                 wr_en_o,
    output logic [num_ways-1:0]                  wr_way_o,
    output cache_pkg::line_t                     wr_line_o,
    output cache_pkg::line_be_t                  wr_be_o,
    output logic                                 fill_o,
    output logic                                 refill_o,
    output logic                                 mem_req_o,
    output logic                                 mem_we_o,
    output logic [cache_pkg::addr_w-1:0]         mem_addr_o,
    output cache_pkg::word_t                     mem_wdata_o,
    output cache_pkg::be_t                       mem_be_o
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_store_merge,
        st_mem_write,
        st_refill_req,
        st_refill_wait
    } state_e;

    state_e state_q, state_d;
    // class of the request in execution
    op_e op_q;
    // way that hit, kept for the store merge
    logic [num_ways-1:0] hit_way_q;
    logic mem_write;

    assign busy_o    = (state_q != st_idle);
    assign mem_write = (state_q == st_store_merge) || (state_q == st_mem_write);

    // ------------------------------
    // memory port
    // ------------------------------
    // outputs come from held values only, so they stay put until mem_gnt_i
    assign mem_req_o   = mem_write || (state_q == st_refill_req);
    assign mem_we_o    = mem_write;
    // word address for writes, line address for refills
    assign mem_addr_o  = mem_write ?
                         {tag_i, index_i, word_sel_i, {(byte_off_w - word_off_w){1'b0}}} :
                         {tag_i, index_i, {byte_off_w{1'b0}}};
    assign mem_wdata_o = wdata_i;
    assign mem_be_o    = be_i;

    // store word goes to every slot, byte enables pick the right one
    assign wr_line_o = refill_o ? mem_rdata_i : {words_per_line{wdata_i}};

    // ------------------------------
    // next state and outputs
    // ------------------------------
    always_comb begin
        state_d  = state_q;
        accept_o = 1'b0;
        gnt_o    = 1'b0;
        rvalid_o = 1'b0;
        rd_en_o  = 1'b0;
        wr_en_o  = 1'b0;
        wr_way_o = hit_way_q;
        wr_be_o  = line_be_t'(be_i) << (word_sel_i * be_w);
        fill_o   = 1'b0;
        refill_o = 1'b0;
        case (state_q)
            st_idle: begin
                if (req_i) begin
                    accept_o = 1'b1;
                    // loads are granted at once, stores after their memory write
                    gnt_o   = (op_i == op_load) || (op_i == op_bypass_load);
                    rd_en_o = (op_i == op_load) || (op_i == op_store);
                    case (op_i)
                        op_load, op_store: state_d = st_lookup;
                        op_bypass_load:    state_d = st_refill_req;
                        default:           state_d = st_mem_write;
                    endcase
                end
            end
            st_lookup: begin
                if (op_q == op_load) begin
                    if (hit_i) begin
                        rvalid_o = 1'b1;
                        // overlap a following cached load
                        if (req_i && op_i == op_load) begin
                            accept_o = 1'b1;
                            gnt_o    = 1'b1;
                            rd_en_o  = 1'b1;
                        end else begin
                            state_d = st_idle;
                        end
                    end else begin
                        state_d = st_refill_req;
                    end
                end else begin
                    // store miss writes memory only
                    state_d = hit_i ? st_store_merge : st_mem_write;
                end
            end
            st_store_merge: begin
                // merge into the hit way while the write-through starts
                wr_en_o = 1'b1;
                if (mem_gnt_i) begin
                    gnt_o   = 1'b1;
                    state_d = st_idle;
                end else begin
                    state_d = st_mem_write;
                end
            end
            st_mem_write: begin
                if (mem_gnt_i) begin
                    gnt_o   = 1'b1;
                    state_d = st_idle;
                end
            end
            st_refill_req: begin
                if (mem_gnt_i) begin
                    state_d = st_refill_wait;
                end
            end
            st_refill_wait: begin
                // critical word comes from the memory line
                refill_o = 1'b1;
                if (mem_rvalid_i) begin
                    rvalid_o = 1'b1;
                    state_d  = st_idle;
                    // bypass loads leave the array alone
                    if (op_q == op_load) begin
                        wr_en_o  = 1'b1;
                        wr_way_o = victim_way_i;
                        wr_be_o  = '1;
                        fill_o   = 1'b1;
                    end
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= st_idle;
            op_q      <= op_load;
            hit_way_q <= '0;
        end else begin
            state_q <= state_d;
            if (accept_o) begin
                op_q <= op_i;
            end
            if (state_q == st_lookup) begin
                hit_way_q <= hit_way_i;
            end
        end
    end

endmodule

// File: logic/resp_select.sv
// result stage: tag compare, way and word select for the core response
`timescale 1ns/10ps

module resp_select #(
    parameter int unsigned num_ways = 2,
    parameter int unsigned num_sets = 16,
    localparam int unsigned tag_w = cache_pkg::addr_w - $clog2(num_sets) - cache_pkg::byte_off_w
) (
    input  logic [num_ways-1:0][tag_w-1:0]       tags_i,
    input  logic [num_ways-1:0]                  valids_i,
    input  cache_pkg::line_t [num_ways-1:0]      lines_i,
    input  logic [tag_w-1:0]                     held_tag_i,
    input  logic [cache_pkg::word_off_w-1:0]     word_sel_i,
    input  logic                                 refill_i,
    input  cache_pkg::line_t                     mem_rdata_i,
    output logic [num_ways-1:0]                  hit_way_o,
    output logic                                 hit_o,
    output cache_pkg::word_t                     rdata_o
);
    import cache_pkg::*;

    line_t hit_line;
    line_t sel_line;

    // compare all ways, at most one can match
    always_comb begin
        hit_line = '0;
        for (int unsigned w = 0; w < num_ways; w++) begin
            hit_way_o[w] = valids_i[w] && (tags_i[w] == held_tag_i);
            if (hit_way_o[w]) begin
                hit_line = hit_line | lines_i[w];
            end
        end
    end

    assign hit_o = |hit_way_o;

    // memory line wins during a refill
    assign sel_line = refill_i ? mem_rdata_i : hit_line;
    assign rdata_o  = sel_line[word_sel_i * word_w +: word_w];

endmodule

// File: logic/cache_ctrl.sv
// data cache controller top: two-way write-through cache between core and memory
`timescale 1ns/10ps

module cache_ctrl #(
    parameter int unsigned num_ways = 2,
    parameter int unsigned num_sets = 16
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         req_i,
    input  logic                         we_i,
    input  logic                         bypass_i,
    input  logic [cache_pkg::addr_w-1:0] addr_i,
    input  cache_pkg::be_t               be_i,
    input  cache_pkg::word_t             wdata_i,
    output logic                         gnt_o,
    output logic                         rvalid_o,
    output cache_pkg::word_t             rdata_o,
    output logic                         busy_o,
    output logic                         mem_req_o,
    output logic                         mem_we_o,
    output logic [cache_pkg::addr_w-1:0] mem_addr_o,
    output cache_pkg::word_t             mem_wdata_o,
    output cache_pkg::be_t               mem_be_o,
    input  logic                         mem_gnt_i,
    input  logic                         mem_rvalid_i,
    input  cache_pkg::line_t             mem_rdata_i
);
    import cache_pkg::*;

    localparam int unsigned idx_w = $clog2(num_sets);
    localparam int unsigned tag_w = addr_w - idx_w - byte_off_w;

    // ------------------------------
    // decode to execute
    // ------------------------------
    logic [idx_w-1:0] rd_index;
    op_e op;
    logic [tag_w-1:0] tag;
    logic [idx_w-1:0] index;
    logic [word_off_w-1:0] word_sel;
    be_t be;
    word_t wdata;
    logic accept;

    // array control
    logic rd_en, wr_en, fill, refill;
    logic [num_ways-1:0] wr_way;
    line_t wr_line;
    line_be_t wr_be;

    // array and compare results
    logic [num_ways-1:0][tag_w-1:0] tags;
    logic [num_ways-1:0] valids;
    line_t [num_ways-1:0] lines;
    logic [num_ways-1:0] victim_way, hit_way;
    logic hit;

    req_decode #(.num_sets(num_sets)) req_decode_i (
        .clk_i, .rst_ni, .req_i, .we_i, .bypass_i, .addr_i, .be_i, .wdata_i,
        .accept_i(accept), .rd_index_o(rd_index), .op_o(op), .tag_o(tag),
        .index_o(index), .word_sel_o(word_sel), .be_o(be), .wdata_o(wdata)
    );

    ctrl_fsm #(.num_ways(num_ways), .num_sets(num_sets)) ctrl_fsm_i (
        .clk_i, .rst_ni, .req_i, .op_i(op), .tag_i(tag), .index_i(index),
        .word_sel_i(word_sel), .be_i(be), .wdata_i(wdata), .hit_i(hit),
        .hit_way_i(hit_way), .victim_way_i(victim_way), .mem_gnt_i, .mem_rvalid_i,
        .mem_rdata_i, .accept_o(accept), .gnt_o, .rvalid_o, .busy_o, .rd_en_o(rd_en),
        .wr_en_o(wr_en), .wr_way_o(wr_way), .wr_line_o(wr_line), .wr_be_o(wr_be),
        .fill_o(fill), .refill_o(refill), .mem_req_o, .mem_we_o, .mem_addr_o,
        .mem_wdata_o, .mem_be_o
    );

    // writes and victim choice always refer to the held set
    cache_array #(.num_ways(num_ways), .num_sets(num_sets)) cache_array_i (
        .clk_i, .rst_ni, .rd_en_i(rd_en), .rd_index_i(rd_index), .wr_en_i(wr_en),
        .wr_way_i(wr_way), .wr_index_i(index), .wr_tag_i(tag), .wr_line_i(wr_line),
        .wr_be_i(wr_be), .fill_i(fill), .victim_index_i(index), .tags_o(tags),
        .valids_o(valids), .lines_o(lines), .victim_way_o(victim_way)
    );

    resp_select #(.num_ways(num_ways), .num_sets(num_sets)) resp_select_i (
        .tags_i(tags), .valids_i(valids), .lines_i(lines), .held_tag_i(tag),
        .word_sel_i(word_sel), .refill_i(refill), .mem_rdata_i, .hit_way_o(hit_way),
        .hit_o(hit), .rdata_o
    );

endmodule

// File: verif/tb_clk_gen.sv
// testbench clock and reset generator: 40 ns clock, reset held for two cycles
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int unsigned period = 40,
    parameter int unsigned rst_cycles = 2
) (
    output logic clk_o,
    output logic rst_no
);
    initial begin
        clk_o = 1'b0;
        forever #(period / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, away from the active clock edge
    initial begin
        rst_no = 1'b0;
        repeat (rst_cycles) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

// File: verif/cache_ctrl_tb.sv
// cache controller testbench: file driven accesses against a line-wide memory model
`timescale 1ns/10ps

module cache_ctrl_tb;
    import cache_pkg::*;

    logic clk, rst_n;
    logic req, we, bypass, mem_gnt, mem_rvalid;
    logic [31:0] addr;
    be_t be;
    word_t wdata;
    line_t mem_rdata;
    logic gnt, rvalid, busy, mem_req, mem_we;
    word_t rdata, mem_wdata;
    logic [31:0] mem_addr;
    be_t mem_be;

    // memory contents that differ from the fill rule, keyed by word address
    word_t mem_q [logic [31:0]];
    integer seed = 32'he460f563;
    int reads;
    int data_errs = 0;
    int read_errs = 0;
    int other_errs = 0;
    int n_lines = 0;
    logic loaded = 1'b0;

    // stimulus columns
    string q_name[$];
    logic q_we[$], q_byp[$];
    logic [31:0] q_addr[$];
    be_t q_be[$];
    word_t q_wdata[$], q_exp[$];
    int q_reads[$];

    tb_clk_gen clk_gen_i (.clk_o(clk), .rst_no(rst_n));

    cache_ctrl dut_i (
        .clk_i(clk), .rst_ni(rst_n), .req_i(req), .we_i(we), .bypass_i(bypass),
        .addr_i(addr), .be_i(be), .wdata_i(wdata), .gnt_o(gnt), .rvalid_o(rvalid),
        .rdata_o(rdata), .busy_o(busy), .mem_req_o(mem_req), .mem_we_o(mem_we),
        .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata), .mem_be_o(mem_be),
        .mem_gnt_i(mem_gnt), .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata)
    );

    // untouched words hold their address next to its inverse
    function automatic word_t mem_word(input logic [31:0] a);
        if (mem_q.exists(a)) begin
            return mem_q[a];
        end
        return {a, ~a};
    endfunction

    // a cached load whose line the stimulus expects to be present
    function automatic logic expects_hit(input int i);
        return !q_we[i] && !q_byp[i] && q_reads[i] == 0;
    endfunction

    // ------------------------------
    // memory model
    // ------------------------------
    initial begin
        logic [31:0] a;
        logic is_wr;
        word_t w;
        mem_gnt = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                repeat ($unsigned($random(seed)) % 4) @(negedge clk);
                mem_gnt = 1'b1;
                a = mem_addr;
                // the request drops once granted, so keep its direction
                is_wr = mem_we;
                if (is_wr) begin
                    w = mem_word({a[31:3], 3'b000});
                    for (int b = 0; b < be_w; b++) begin
                        if (mem_be[b]) begin
                            w[b*8 +: 8] = mem_wdata[b*8 +: 8];
                        end
                    end
                    mem_q[{a[31:3], 3'b000}] = w;
                end else begin
                    reads++;
                end
                @(negedge clk);
                mem_gnt = 1'b0;
                if (!is_wr) begin
                    repeat ($unsigned($random(seed)) % 4) @(negedge clk);
                    // upper word sits in the upper half of the line
                    mem_rdata = {mem_word({a[31:4], 4'h8}), mem_word({a[31:4], 4'h0})};
                    mem_rvalid = 1'b1;
                    @(negedge clk);
                    mem_rvalid = 1'b0;
                end
            end
        end
    end

    // one access: request until grant, then wait for the load data
    task automatic run_access(input int i);
        word_t got;
        @(negedge clk);
        reads = 0;
        req = 1'b1;
        we = q_we[i];
        bypass = q_byp[i];
        addr = q_addr[i];
        be = q_be[i];
        wdata = q_wdata[i];
        @(posedge clk);
        while (!gnt) @(posedge clk);
        if (q_we[i] && !busy) begin
            $display("busy was low while %s was writing memory", q_name[i]);
            other_errs++;
        end
        @(negedge clk);
        req = 1'b0;
        if (!q_we[i]) begin
            @(posedge clk);
            while (!rvalid) @(posedge clk);
            got = rdata;
            if (!busy) begin
                $display("busy was low while %s returned its data", q_name[i]);
                other_errs++;
            end
            if (got !== q_exp[i]) begin
                $display("FAILED %s data expected %h actual %h", q_name[i], q_exp[i], got);
                data_errs++;
            end
        end
        if (reads != q_reads[i]) begin
            $display("FAILED %s memory reads expected %0d actual %0d",
                     q_name[i], q_reads[i], reads);
            read_errs++;
        end
    endtask

    // cached loads that should all hit, issued back to back
    // each result is due one cycle after its grant
    task automatic burst_hit_loads(input int first, input int last);
        int issue;
        int done;
        logic granted;
        issue = first;
        done = first;
        granted = 1'b0;
        @(negedge clk);
        reads = 0;
        req = 1'b1;
        we = 1'b0;
        bypass = 1'b0;
        addr = q_addr[first];
        be = q_be[first];
        wdata = q_wdata[first];
        while (done <= last) begin
            @(posedge clk);
            if (rvalid !== granted) begin
                $display("load result for %s was not one cycle after its grant",
                         q_name[done]);
                other_errs++;
            end
            if (rvalid) begin
                if (rdata !== q_exp[done]) begin
                    $display("FAILED %s data expected %h actual %h",
                             q_name[done], q_exp[done], rdata);
                    data_errs++;
                end
                if (!busy) begin
                    $display("busy was low while %s returned its data", q_name[done]);
                    other_errs++;
                end
                done++;
            end
            granted = req && gnt;
            if (granted) begin
                issue++;
            end
            @(negedge clk);
            if (issue > last) begin
                req = 1'b0;
            end else begin
                addr = q_addr[issue];
                be = q_be[issue];
                wdata = q_wdata[issue];
            end
        end
        if (reads != 0) begin
            $display("FAILED %s memory reads expected 0 actual %0d", q_name[first], reads);
            read_errs++;
        end
    endtask

    // ------------------------------
    // stimulus and checks
    // ------------------------------
    initial begin
        int fd;
        int cnt;
        int first;
        int last;
        string line, name;
        logic [31:0] f_we, f_byp, f_addr, f_be;
        word_t f_wdata, f_exp;
        int f_reads;
        req = 1'b0;
        we = 1'b0;
        bypass = 1'b0;
        addr = '0;
        be = '0;
        wdata = '0;
        fd = $fopen("verif/cache_ctrl_stim.txt", "r");
        if (fd == 0) begin
            $display("stimulus file could not be opened");
            other_errs++;
        end else begin
            while (!$feof(fd)) begin
                cnt = $fgets(line, fd);
                if (cnt > 0 && line[0] != 8'h23) begin
                    cnt = $sscanf(line, "%s %h %h %h %h %h %h %d", name, f_we, f_byp,
                                  f_addr, f_be, f_wdata, f_exp, f_reads);
                    if (cnt == 8) begin
                        q_name.push_back(name);
                        q_we.push_back(f_we[0]);
                        q_byp.push_back(f_byp[0]);
                        q_addr.push_back(f_addr);
                        q_be.push_back(be_t'(f_be));
                        q_wdata.push_back(f_wdata);
                        q_exp.push_back(f_exp);
                        q_reads.push_back(f_reads);
                    end
                end
            end
            $fclose(fd);
        end
        n_lines = q_name.size();
        loaded = 1'b1;
        wait (rst_n);
        @(negedge clk);
        // nothing may be active straight out of reset
        if (gnt || rvalid || mem_req || busy) begin
            $display("control outputs were not all low after reset");
            other_errs++;
        end
        // runs of expected hits go out back to back
        first = 0;
        while (first < n_lines) begin
            last = first;
            if (expects_hit(first)) begin
                while (last + 1 < n_lines && expects_hit(last + 1)) begin
                    last++;
                end
                burst_hit_loads(first, last);
            end else begin
                run_access(first);
            end
            first = last + 1;
        end
        repeat (2) @(negedge clk);
        $display("errors: data %0d, memory reads %0d, other %0d",
                 data_errs, read_errs, other_errs);
        if (data_errs + read_errs + other_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog, scaled by the number of accesses
    initial begin
        wait (loaded);
        #((n_lines + 1) * 60 * 40);
        $display("run did not finish in time, an access never completed");
        $display("Errors found");
        $finish;
    end

endmodule

// File: cache_ctrl.f
logic/cache_pkg.sv
logic/req_decode.sv
logic/cache_array.sv
logic/ctrl_fsm.sv
logic/resp_select.sv
logic/cache_ctrl.sv
verif/tb_clk_gen.sv
verif/cache_ctrl_tb.sv

// File: Makefile
# Verilator build and run of the cache controller testbench

VERILATOR ?= verilator
TOP       ?= cache_ctrl_tb
FLIST     ?= cache_ctrl.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SRCS := $(wildcard logic/*.sv) $(wildcard verif/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/cache_ctrl_stim.txt
# name we bypass addr be wdata expected_rdata expected_memory_reads
# hex fields except the last, which is decimal; expected_rdata is ignored for stores
ld_first        0 0 00001000 ff 0000000000000000 00001000ffffefff 1
ld_repeat       0 0 00001000 ff 0000000000000000 00001000ffffefff 0
ld_other_word   0 0 00001008 ff 0000000000000000 00001008ffffeff7 0
st_hit          1 0 00001008 0f 1122334455667788 0000000000000000 0
ld_after_st     0 0 00001008 ff 0000000000000000 0000100855667788 0
byp_after_st    0 1 00001008 ff 0000000000000000 0000100855667788 1
st_miss         1 0 00002010 f0 aabbccdd00000000 0000000000000000 0
ld_after_miss   0 0 00002010 ff 0000000000000000 aabbccddffffdfef 1
byp_ld_a        0 1 00001000 ff 0000000000000000 00001000ffffefff 1
byp_ld_b        0 1 00001000 ff 0000000000000000 00001000ffffefff 1
ld_still_cached 0 0 00001000 ff 0000000000000000 00001000ffffefff 0
ld_set5_a       0 0 00003050 ff 0000000000000000 00003050ffffcfaf 1
ld_set5_b       0 0 00004050 ff 0000000000000000 00004050ffffbfaf 1
ld_set5_c       0 0 00005050 ff 0000000000000000 00005050ffffafaf 1
ld_set5_b_hit   0 0 00004050 ff 0000000000000000 00004050ffffbfaf 0
ld_set5_a_again 0 0 00003050 ff 0000000000000000 00003050ffffcfaf 1
ld_set5_c_hit   0 0 00005050 ff 0000000000000000 00005050ffffafaf 0
ld_hit_1        0 0 00001000 ff 0000000000000000 00001000ffffefff 0
ld_hit_2        0 0 00001008 ff 0000000000000000 0000100855667788 0
ld_hit_3        0 0 00002010 ff 0000000000000000 aabbccddffffdfef 0
